//--- design/panel_params.svh
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// matrix geometry, rows and columns alike
`define PANEL_ROWS 8

// heat level saturates here
`define PANEL_MAX_LEVEL 7

// enabled clocks per level step
`define HEAT_STEP_TICKS 16

// alarm hysteresis band on the temperature code
`define TEMP_HIGH 200
`define TEMP_LOW 180

`endif

//--- design/panel_pkg.sv
`include "panel_params.svh"

package panel_pkg;

    // glyph table is indexed 0..15, so four bits
    typedef logic [3:0] level_t;

    typedef logic [$clog2(`PANEL_ROWS)-1:0] row_idx_t;

    // one column or row pattern of the matrix
    typedef logic [`PANEL_ROWS-1:0] col_t;

    typedef logic [7:0] temp_t; // sampled sensor code

endpackage

//--- design/heat_progress.sv
`timescale 1ns/1ps
`include "panel_params.svh"

module heat_progress (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    output panel_pkg::level_t level
);

    localparam int TICK_W = $clog2(`HEAT_STEP_TICKS);

    logic [TICK_W-1:0] tick;
    logic              step;
    logic              at_max;

    assign step   = (tick == TICK_W'(`HEAT_STEP_TICKS - 1));
    assign at_max = (level >= panel_pkg::level_t'(`PANEL_MAX_LEVEL));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick  <= '0;
            level <= '0;
        end
        else if (!st)
        begin
            // heating off, start over from cold
            tick  <= '0;
            level <= '0;
        end
        else if (step)
        begin
            tick <= '0;
            if (!at_max)
            begin
                level <= level + 1'b1;
            end
        end
        else
        begin
            tick <= tick + 1'b1;
        end
    end

    level_in_range: assert property (
        @(posedge clk) disable iff (rst)
        level <= panel_pkg::level_t'(`PANEL_MAX_LEVEL)
    ) else $error("heat level %0d above max", level);

endmodule

//--- design/temp_alarm.sv
`timescale 1ns/1ps
`include "panel_params.svh"

module temp_alarm (
    input  logic             clk,
    input  logic             rst,
    input  panel_pkg::temp_t temp_code,
    output logic             alarm
);

    logic too_hot;
    logic cooled;

    assign too_hot = (temp_code >= panel_pkg::temp_t'(`TEMP_HIGH));
    assign cooled  = (temp_code < panel_pkg::temp_t'(`TEMP_LOW));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            alarm <= 1'b0;
        end
        else if (too_hot)
        begin
            alarm <= 1'b1;
        end
        else if (cooled)
        begin
            alarm <= 1'b0;
        end
        // inside the band, hold
    end

    alarm_follows_high: assert property (
        @(posedge clk) disable iff (rst)
        too_hot |=> alarm
    ) else $error("alarm missed a high temperature sample");

endmodule

//--- design/level_glyphs.sv
`timescale 1ns/1ps

module level_glyphs (
    input  panel_pkg::level_t   level,
    input  panel_pkg::row_idx_t scan_row,
    output panel_pkg::col_t     glyph
);

    always_comb
    begin
        glyph = '0;
        case (level)
            4'd0:
            begin
                case (scan_row)
                    3'd2, 3'd5: glyph = 8'b0001_1000;
                    3'd3, 3'd4: glyph = 8'b0011_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            4'd1:
            begin
                case (scan_row)
                    3'd2, 3'd5: glyph = 8'b0011_1000;
                    3'd3, 3'd4: glyph = 8'b0111_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            4'd2:
            begin
                case (scan_row)
                    3'd2, 3'd5: glyph = 8'b0011_1100;
                    3'd3, 3'd4: glyph = 8'b0111_1110;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            4'd3:
            begin
                case (scan_row)
                    3'd1, 3'd6:             glyph = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: glyph = 8'b0111_1110;
                    default:                glyph = 8'b0000_0000;
                endcase
            end
            4'd4:
            begin
                case (scan_row)
                    3'd0, 3'd7: glyph = 8'b0011_1100;
                    3'd1, 3'd6: glyph = 8'b0111_1110;
                    default:    glyph = 8'b1111_1111; // middle four rows
                endcase
            end
            4'd5:
            begin
                glyph = 8'b1111_1111;
            end
            4'd6:
            begin
                // first flame
                case (scan_row)
                    3'd0:    glyph = 8'b1100_0011;
                    3'd1:    glyph = 8'b1110_0011;
                    3'd2:    glyph = 8'b1111_0001;
                    3'd3:    glyph = 8'b1110_0011;
                    3'd4:    glyph = 8'b1100_0111;
                    3'd5:    glyph = 8'b1110_0111;
                    3'd6:    glyph = 8'b1111_0111;
                    default: glyph = 8'b1111_1011;
                endcase
            end
            4'd7:
            begin
                case (scan_row)
                    3'd1:    glyph = 8'b0000_0001;
                    3'd2:    glyph = 8'b1000_0001;
                    3'd3:    glyph = 8'b1100_0011;
                    3'd4:    glyph = 8'b1000_0011;
                    3'd5:    glyph = 8'b1100_0111;
                    3'd6:    glyph = 8'b1110_0111;
                    3'd7:    glyph = 8'b1111_0011;
                    default: glyph = 8'b0000_0000; // top row dark
                endcase
            end
            default:
            begin
                glyph = 8'b0000_0000; // levels 8 and up unused
            end
        endcase
    end

endmodule

//--- design/matrix_driver.sv
`timescale 1ns/1ps
`include "panel_params.svh"

module matrix_driver (
    input  logic                clk,
    input  logic                rst,
    input  logic                alarm,
    input  panel_pkg::col_t     glyph,
    output panel_pkg::row_idx_t scan_row,
    output panel_pkg::col_t     row,
    output panel_pkg::col_t     colg,
    output panel_pkg::col_t     colr
);

    logic last_row;

    assign last_row = (scan_row == panel_pkg::row_idx_t'(`PANEL_ROWS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_row <= '0;
        end
        else if (last_row)
        begin
            scan_row <= '0;
        end
        else
        begin
            scan_row <= scan_row + 1'b1;
        end
    end

    // rows are active low, one lit per clock
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~(panel_pkg::col_t'(1) << scan_row);
            colg <= glyph;
            colr <= alarm ? glyph : '0; // red over green gives amber
        end
    end

    one_row_lit: assert property (
        @(posedge clk) disable iff (rst)
        !rst |=> $onehot(~row)
    ) else $error("row pattern %b not a single active row", row);

endmodule

//--- design/heater_panel.sv
`timescale 1ns/1ps

module heater_panel (
    input  logic             clk,
    input  logic             rst,
    input  logic             st,
    input  panel_pkg::temp_t temp_code,
    output panel_pkg::col_t  row,
    output panel_pkg::col_t  colg,
    output panel_pkg::col_t  colr
);

    panel_pkg::level_t   level;
    panel_pkg::row_idx_t scan_row;
    panel_pkg::col_t     glyph;
    logic                alarm;

    heat_progress heat_progress_inst (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .level (level)
    );

    temp_alarm temp_alarm_inst (
        .clk       (clk),
        .rst       (rst),
        .temp_code (temp_code),
        .alarm     (alarm)
    );

    level_glyphs level_glyphs_inst (
        .level    (level),
        .scan_row (scan_row),
        .glyph    (glyph)
    );

    matrix_driver matrix_driver_inst (
        .clk      (clk),
        .rst      (rst),
        .alarm    (alarm),
        .glyph    (glyph),
        .scan_row (scan_row),
        .row      (row),
        .colg     (colg),
        .colr     (colr)
    );

endmodule

//--- bench/heater_panel_tb.sv
`timescale 1ns/1ps
`include "panel_params.svh"

module heater_panel_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int N_RUNS       = 40;
    localparam int MAX_RUN      = 200;
    localparam int MID_RESET_AT = 20; // run index of the second reset pulse
    localparam int MAX_CYCLES   = 2 * RESET_CYCLES + N_RUNS * MAX_RUN + 200;

    logic            clk = 1'b0;
    logic            rst;
    logic            st;
    panel_pkg::temp_t temp_code;
    panel_pkg::col_t row;
    panel_pkg::col_t colg;
    panel_pkg::col_t colr;

    integer seed;
    int     errors;
    int     checks;

    // reference model state
    int         m_tick;
    int         m_level;
    logic       m_alarm;
    logic [2:0] m_scan;
    logic [7:0] model_glyph;
    logic [7:0] exp_row;
    logic [7:0] exp_colg;
    logic [7:0] exp_colr;

    heater_panel heater_panel_inst (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp_code (temp_code),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // row 0 is the top byte of each pattern
    function automatic logic [7:0] glyph_row(input int level, input int idx);
        logic [63:0] pat;
        case (level)
            0:       pat = 64'h0000_183c_3c18_0000;
            1:       pat = 64'h0000_387c_7c38_0000;
            2:       pat = 64'h0000_3c7e_7e3c_0000;
            3:       pat = 64'h003c_7e7e_7e7e_3c00;
            4:       pat = 64'h3c7e_ffff_ffff_7e3c;
            5:       pat = 64'hffff_ffff_ffff_ffff;
            6:       pat = 64'hc3e3_f1e3_c7e7_f7fb;
            7:       pat = 64'h0001_81c3_83c7_e7f3;
            default: pat = 64'h0;
        endcase
        return pat[63 - 8 * idx -: 8];
    endfunction

    assign model_glyph = glyph_row(m_level, int'(m_scan));

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_tick   <= 0;
            m_level  <= 0;
            m_alarm  <= 1'b0;
            m_scan   <= 3'd0;
            exp_row  <= 8'hff;
            exp_colg <= 8'h00;
            exp_colr <= 8'h00;
        end
        else
        begin
            exp_row  <= ~(8'h01 << m_scan);
            exp_colg <= model_glyph;
            exp_colr <= m_alarm ? model_glyph : 8'h00;
            m_scan   <= m_scan + 3'd1; // wraps at 8
            if (!st)
            begin
                m_tick  <= 0;
                m_level <= 0;
            end
            else if (m_tick == `HEAT_STEP_TICKS - 1)
            begin
                m_tick <= 0;
                if (m_level < `PANEL_MAX_LEVEL)
                    m_level <= m_level + 1;
            end
            else
            begin
                m_tick <= m_tick + 1;
            end
            if (temp_code >= 8'(`TEMP_HIGH))
                m_alarm <= 1'b1;
            else if (temp_code < 8'(`TEMP_LOW))
                m_alarm <= 1'b0;
        end
    end

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // outputs are settled halfway through the cycle
    always @(negedge clk)
    begin
        if (rst)
        begin
            compare_byte("reset_row", 8'hff, row);
            compare_byte("reset_colg", 8'h00, colg);
            compare_byte("reset_colr", 8'h00, colr);
        end
        else
        begin
            compare_byte("row_scan", exp_row, row);
            compare_byte("level_glyph", exp_colg, colg);
            compare_byte("alarm_red", exp_colr, colr);
            if (row !== 8'hff)
            begin
                checks++;
                assert ($countones(~row) == 1)
                else
                begin
                    errors++;
                    $display("row output %b does not light exactly one row", row);
                end
            end
        end
    end

    function automatic logic [7:0] random_temp();
        if ({$random(seed)} % 2 == 0)
            return 8'(170 + {$random(seed)} % 41); // around both thresholds
        else
            return 8'({$random(seed)} % 256);
    endfunction

    task automatic drive_run(input logic level, input int len);
        repeat (len)
        begin
            @(posedge clk);
            st        <= level;
            temp_code <= random_temp();
        end
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge clk);
        rst <= 1'b1;
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial
    begin
        int   len;
        logic st_level;
        seed      = 32'hb9c6;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        st        = 1'b0;
        temp_code = 8'd0;
        st_level  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_RUNS; i++)
        begin
            if (i == MID_RESET_AT)
                pulse_reset(RESET_CYCLES);
            st_level = ~st_level;
            len = 1 + {$random(seed)} % MAX_RUN;
            drive_run(st_level, len);
        end
        repeat (4) @(posedge clk); // let the pipeline drain
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, stimulus never finished", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- heater_panel.f
+incdir+design
design/panel_pkg.sv
design/heat_progress.sv
design/temp_alarm.sv
design/level_glyphs.sv
design/matrix_driver.sv
design/heater_panel.sv
bench/heater_panel_tb.sv

//--- Makefile
# Verilator build and run for the heater panel testbench

SIM := obj_dir/Vheater_panel_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): heater_panel.f design/*.sv design/*.svh bench/*.sv
	verilator --binary --timing --assert -f heater_panel.f --top-module heater_panel_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
